// ==== bench/mul_unit_tb.sv ====
`timescale 1ns/1ns

module mul_unit_tb import mul_pkg::*; ();

    localparam int xlen = 32;
    localparam int period = 20;
    localparam int half = period / 2;
    localparam int drain_limit = 1000;

    logic                 clk;
    logic                 rst;
    logic                 start;
    mul_op_t              op;
    logic [xlen-1:0]      a;
    logic [xlen-1:0]      b;
    logic [prd_width-1:0] prd;
    logic [pc_width-1:0]  pc;
    logic                 done;
    logic [xlen-1:0]      result;
    logic [prd_width-1:0] prd_out;
    logic [pc_width-1:0]  pc_out;

    // scoreboard holds one entry per started op in issue order
    logic [xlen-1:0]      exp_q[$];
    logic [prd_width-1:0] prd_q[$];
    logic [pc_width-1:0]  pc_q[$];
    time                  start_q[$];

    logic [prd_width-1:0] next_prd;
    logic [pc_width-1:0]  next_pc;
    logic [xlen-1:0]      corners [0:7];
    int                   checks;
    int                   errors;
    int                   start_count;
    int                   done_count;

    mul_unit #(.xlen(xlen)) dut (
        .clk(clk), .rst(rst), .start(start), .op(op), .a(a), .b(b), .prd(prd), .pc(pc),
        .done(done), .result(result), .prd_out(prd_out), .pc_out(pc_out)
    );

    initial begin
        clk = 1'b0;
        forever #half clk = ~clk;
    end

    // RV32M result from the extended 2*xlen product
    function automatic logic [xlen-1:0] mul_model(mul_op_t o, logic [xlen-1:0] x,
                                                  logic [xlen-1:0] y);
        logic [2*xlen-1:0] ext_x;
        logic [2*xlen-1:0] ext_y;
        logic [2*xlen-1:0] full;
        ext_x = {{xlen{1'b0}}, x};
        ext_y = {{xlen{1'b0}}, y};
        if (o == op_mulh || o == op_mulhsu) begin
            ext_x = {{xlen{x[xlen-1]}}, x};
        end
        if (o == op_mulh) begin
            ext_y = {{xlen{y[xlen-1]}}, y};
        end
        full = ext_x * ext_y;
        return (o == op_mul) ? full[xlen-1:0] : full[2*xlen-1:xlen];
    endfunction

    task automatic issue_op(input mul_op_t o, input logic [xlen-1:0] x,
                            input logic [xlen-1:0] y);
        @(posedge clk);
        start <= 1'b1;
        op    <= o;
        a     <= x;
        b     <= y;
        prd   <= next_prd;
        pc    <= next_pc;
        exp_q.push_back(mul_model(o, x, y));
        prd_q.push_back(next_prd);
        pc_q.push_back(next_pc);
        start_q.push_back($time);
        start_count++;
        next_prd = next_prd + 1;
        next_pc  = next_pc + 4;
    endtask

    task automatic go_idle();
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < drain_limit) begin
            @(posedge clk);
            cycles++;
        end
        checks++;
        assert (exp_q.size() == 0) else begin
            $display("timeout: %0d results still missing after %0d cycles",
                     exp_q.size(), drain_limit);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst   <= 1'b1;
        start <= 1'b0;
        exp_q.delete();
        prd_q.delete();
        pc_q.delete();
        start_q.delete();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    // outputs stay idle over a window of cycles
    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            checks++;
            assert (done == 1'b0 && result == '0 && prd_out == '0 && pc_out == '0) else begin
                $display("Error: %0t ns: quiet window, done %b result %h prd %h pc %h",
                         $time, done, result, prd_out, pc_out);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s: %s, %0d errors", name,
                 (errors == errors_before) ? "ok" : "failed", errors - errors_before);
    endtask

    // pops one entry per done at the falling edge where outputs are stable
    always @(negedge clk) begin : compare_outputs
        logic [xlen-1:0]      exp_result;
        logic [prd_width-1:0] exp_prd;
        logic [pc_width-1:0]  exp_pc;
        time                  t0;
        if (!rst && done) begin
            done_count++;
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("done seen at %0t ns with no operation outstanding", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp_result = exp_q.pop_front();
                exp_prd    = prd_q.pop_front();
                exp_pc     = pc_q.pop_front();
                t0         = start_q.pop_front();
                checks     = checks + 3;
                assert (result == exp_result) else begin
                    $display("Error: %0t ns: result %h, expected %h for prd %h",
                             $time, result, exp_result, exp_prd);
                    errors++;
                end
                assert (prd_out == exp_prd && pc_out == exp_pc) else begin
                    $display("Error: %0t ns: tags prd %h pc %h, expected prd %h pc %h",
                             $time, prd_out, pc_out, exp_prd, exp_pc);
                    errors++;
                end
                // last rising edge sits half a period back
                assert (($time - half) - t0 == mul_latency * period) else begin
                    $display("Error: %0t ns: done for prd %h after %0t ns, expected %0d cycles",
                             $time, exp_prd, ($time - half) - t0, mul_latency);
                    errors++;
                end
            end
        end
    end

    initial begin
        int      e0;
        int      gap;
        mul_op_t o;

        void'($urandom(32'hf97));
        rst      <= 1'b1;
        start    <= 1'b0;
        op       <= op_mul;
        a        <= '0;
        b        <= '0;
        prd      <= '0;
        pc       <= '0;
        next_prd = '0;
        next_pc  = 32'h0000_1000;
        checks   = 0;
        errors   = 0;
        corners  = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000,
                     32'h7fff_ffff, 32'h0000_0002, 32'hffff_fffe, 32'h1234_5678};
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            checks++;
            assert (done == 0 && result == 0 && prd_out == 0 && pc_out == 0) else begin
                $display("Error: %0t ns: outputs not idle (done %b result %h prd %h pc %h)",
                         $time, done, result, prd_out, pc_out);
                errors++;
            end
        end
        report_test("idle after reset", e0);

        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 8; i++) begin
                for (int j = 0; j < 8; j++) begin
                    issue_op(mul_op_t'(k), corners[i], corners[j]);
                end
            end
        end
        go_idle();
        wait_drain();
        report_test("corner operands", e0);

        e0 = errors;
        for (int i = 0; i < 300; i++) begin
            o = mul_op_t'($urandom_range(3, 0));
            issue_op(o, $urandom, $urandom);
        end
        go_idle();
        wait_drain();
        report_test("back to back random", e0);

        e0 = errors;
        start_count = 0;
        done_count  = 0;
        for (int i = 0; i < 100; i++) begin
            o = mul_op_t'($urandom_range(3, 0));
            issue_op(o, $urandom, $urandom);
            gap = $urandom_range(5, 0);
            for (int g = 0; g < gap; g++) begin
                go_idle();
            end
        end
        go_idle();
        wait_drain();
        expect_quiet(mul_latency + 2);
        checks++;
        assert (done_count == start_count) else begin
            $display("Error: %0t ns: %0d dones for %0d starts", $time, done_count, start_count);
            errors++;
        end
        report_test("random gaps and latency", e0);

        e0 = errors;
        // some finish before the reset and the rest are still in flight
        for (int i = 0; i < 10; i++) begin
            issue_op(mul_op_t'($urandom_range(3, 0)), $urandom, $urandom);
        end
        apply_reset();
        expect_quiet(mul_latency + 2);
        for (int i = 0; i < 4; i++) begin
            issue_op(mul_op_t'(i), $urandom, $urandom);
        end
        go_idle();
        wait_drain();
        report_test("reset in flight", e0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
logic/mul_pkg.sv
logic/mul_issue_stage.sv
logic/partial_product_stage.sv
logic/csa_reduce_stage.sv
logic/product_resolve_stage.sv
logic/mul_unit.sv
bench/mul_unit_tb.sv

// ==== logic/csa_reduce_stage.sv ====
`timescale 1ns/1ns

module csa_reduce_stage import mul_pkg::*; #(
    parameter int xlen = 32,
    parameter int in_rows = 32,
    localparam int row_w = 2 * xlen,
    // short inputs padded with zero rows so at least two rows come out
    localparam int out_rows = (in_rows > 4) ? in_rows / 2 : 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid_in,
    input  logic [in_rows*row_w-1:0]  rows_in,
    input  logic                      neg_in,
    input  logic                      high_in,
    input  logic [prd_width-1:0]      prd_in,
    input  logic [pc_width-1:0]       pc_in,
    output logic                      valid,
    output logic [out_rows*row_w-1:0] rows_out,
    output logic                      neg,
    output logic                      high,
    output logic [prd_width-1:0]      prd_out,
    output logic [pc_width-1:0]       pc_out
);

    localparam int groups = out_rows / 2;
    localparam int pad_w = 4 * groups * row_w;

    logic [pad_w-1:0]          rows_pad;
    logic [out_rows*row_w-1:0] rows_next;
    logic [row_w-1:0]          in_total;
    logic [row_w-1:0]          out_total;

    // full adder on every bit column with the carry left unshifted
    function automatic void csa3(
        input  logic [row_w-1:0] x,
        input  logic [row_w-1:0] y,
        input  logic [row_w-1:0] z,
        output logic [row_w-1:0] s,
        output logic [row_w-1:0] c
    );
        s = x ^ y ^ z;
        c = (x & y) | (y & z) | (z & x);
    endfunction

    assign rows_pad = pad_w'(rows_in);

    // two chained 3:2 stages make one 4:2 per group
    // carries move one column up so the sum mod 2**row_w is kept
    always_comb begin
        logic [row_w-1:0] r0, r1, r2, r3;
        logic [row_w-1:0] s1, c1, s2, c2;
        for (int g = 0; g < groups; g++) begin
            r0 = rows_pad[(4*g)*row_w +: row_w];
            r1 = rows_pad[(4*g+1)*row_w +: row_w];
            r2 = rows_pad[(4*g+2)*row_w +: row_w];
            r3 = rows_pad[(4*g+3)*row_w +: row_w];
            csa3(r0, r1, r2, s1, c1);
            csa3(s1, c1 << 1, r3, s2, c2);
            rows_next[(2*g)*row_w +: row_w]   = s2;
            rows_next[(2*g+1)*row_w +: row_w] = c2 << 1;
        end
    end

    // modular sum of all rows on both sides of the register
    always_comb begin
        in_total = '0;
        for (int r = 0; r < in_rows; r++) begin
            in_total = in_total + rows_in[r*row_w +: row_w];
        end
        out_total = '0;
        for (int r = 0; r < out_rows; r++) begin
            out_total = out_total + rows_out[r*row_w +: row_w];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        rows_out <= rows_next;
        neg      <= neg_in;
        high     <= high_in;
        prd_out  <= prd_in;
        pc_out   <= pc_in;
    end

    // nothing dropped and the row sum kept across the register
    valid_follows: assert property (
        @(posedge clk) disable iff (rst)
        valid_in |=> valid && (out_total == $past(in_total))
    ) else $error("csa_reduce_stage: valid or row sum lost between input and output");

endmodule

// ==== logic/mul_issue_stage.sv ====
`timescale 1ns/1ns

module mul_issue_stage import mul_pkg::*; #(
    parameter int xlen = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  mul_op_t              op,
    input  logic [xlen-1:0]      a,
    input  logic [xlen-1:0]      b,
    input  logic [prd_width-1:0] prd,
    input  logic [pc_width-1:0]  pc,
    output logic                 valid,
    output logic [xlen-1:0]      mag_a,
    output logic [xlen-1:0]      mag_b,
    output logic                 neg,
    output logic                 high,
    output logic [prd_width-1:0] prd_out,
    output logic [pc_width-1:0]  pc_out
);

    logic a_signed;
    logic b_signed;
    logic a_neg;
    logic b_neg;

    // mul gives the same low word either way, so treat it as unsigned
    assign a_signed = (op == op_mulh) || (op == op_mulhsu);
    assign b_signed = (op == op_mulh);

    // operands the op reads as signed and that are below zero
    assign a_neg = a_signed & a[xlen-1];
    assign b_neg = b_signed & b[xlen-1];

    // idle cycles and reset both leave a zeroed bubble
    always_ff @(posedge clk) begin
        if (rst || !start) begin
            valid   <= 1'b0;
            mag_a   <= '0;
            mag_b   <= '0;
            neg     <= 1'b0;
            high    <= 1'b0;
            prd_out <= '0;
            pc_out  <= '0;
        end else begin
            valid   <= 1'b1;
            // most negative value maps to 2**(xlen-1), still fits unsigned
            mag_a   <= a_neg ? -a : a;
            mag_b   <= b_neg ? -b : b;
            neg     <= a_neg ^ b_neg;
            high    <= (op != op_mul);
            prd_out <= prd;
            pc_out  <= pc;
        end
    end

    op_known: assert property (
        @(posedge clk) disable iff (rst)
        start |-> !$isunknown(op)
    ) else $error("mul_issue_stage: op has unknown bits while start is high");

endmodule

// ==== logic/mul_pkg.sv ====
package mul_pkg;

    // RV32M multiply variants, funct3 order
    typedef enum logic [1:0] {
        // low word of the product
        op_mul    = 2'b00,
        // high word, both operands signed
        op_mulh   = 2'b01,
        // high word, rs1 signed and rs2 unsigned
        op_mulhsu = 2'b10,
        // high word, both unsigned
        op_mulhu  = 2'b11
    } mul_op_t;

    // physical destination register tag
    localparam int prd_width = 8;

    // instruction address carried with the result
    localparam int pc_width = 32;

    // start to done, in clock edges
    // issue 1, partial products 1, four reductions, resolve 1
    localparam int mul_latency = 7;

endpackage

// ==== logic/mul_unit.sv ====
`timescale 1ns/1ns

module mul_unit import mul_pkg::*; #(
    parameter int xlen = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  mul_op_t              op,
    input  logic [xlen-1:0]      a,
    input  logic [xlen-1:0]      b,
    input  logic [prd_width-1:0] prd,
    input  logic [pc_width-1:0]  pc,
    output logic                 done,
    output logic [xlen-1:0]      result,
    output logic [prd_width-1:0] prd_out,
    output logic [pc_width-1:0]  pc_out
);

    localparam int row_w = 2 * xlen;

    // row counts down the tree; names follow the xlen = 32 case
    localparam int rows_32 = xlen;
    localparam int rows_16 = (rows_32 > 4) ? rows_32 / 2 : 2;
    localparam int rows_8 = (rows_16 > 4) ? rows_16 / 2 : 2;
    localparam int rows_4 = (rows_8 > 4) ? rows_8 / 2 : 2;
    localparam int rows_2 = (rows_4 > 4) ? rows_4 / 2 : 2;

    logic                 iss_valid, iss_neg, iss_high;
    logic [xlen-1:0]      iss_mag_a, iss_mag_b;
    logic [prd_width-1:0] iss_prd;
    logic [pc_width-1:0]  iss_pc;

    logic                     pp_valid, pp_neg, pp_high;
    logic [rows_32*row_w-1:0] pp_rows;
    logic [prd_width-1:0]     pp_prd;
    logic [pc_width-1:0]      pp_pc;

    logic                     r16_valid, r16_neg, r16_high;
    logic [rows_16*row_w-1:0] r16_rows;
    logic [prd_width-1:0]     r16_prd;
    logic [pc_width-1:0]      r16_pc;

    logic                    r8_valid, r8_neg, r8_high;
    logic [rows_8*row_w-1:0] r8_rows;
    logic [prd_width-1:0]    r8_prd;
    logic [pc_width-1:0]     r8_pc;

    logic                    r4_valid, r4_neg, r4_high;
    logic [rows_4*row_w-1:0] r4_rows;
    logic [prd_width-1:0]    r4_prd;
    logic [pc_width-1:0]     r4_pc;

    logic                    r2_valid, r2_neg, r2_high;
    logic [rows_2*row_w-1:0] r2_rows;
    logic [prd_width-1:0]    r2_prd;
    logic [pc_width-1:0]     r2_pc;

    mul_issue_stage #(.xlen(xlen)) issue (
        .clk(clk), .rst(rst), .start(start), .op(op), .a(a), .b(b), .prd(prd), .pc(pc),
        .valid(iss_valid), .mag_a(iss_mag_a), .mag_b(iss_mag_b), .neg(iss_neg),
        .high(iss_high), .prd_out(iss_prd), .pc_out(iss_pc)
    );

    partial_product_stage #(.xlen(xlen)) partials (
        .clk(clk), .rst(rst), .valid_in(iss_valid), .mag_a(iss_mag_a), .mag_b(iss_mag_b),
        .neg_in(iss_neg), .high_in(iss_high), .prd_in(iss_prd), .pc_in(iss_pc),
        .valid(pp_valid), .rows(pp_rows), .neg(pp_neg), .high(pp_high),
        .prd_out(pp_prd), .pc_out(pp_pc)
    );

    csa_reduce_stage #(.xlen(xlen), .in_rows(rows_32)) reduce_32 (
        .clk(clk), .rst(rst), .valid_in(pp_valid), .rows_in(pp_rows), .neg_in(pp_neg),
        .high_in(pp_high), .prd_in(pp_prd), .pc_in(pp_pc),
        .valid(r16_valid), .rows_out(r16_rows), .neg(r16_neg), .high(r16_high),
        .prd_out(r16_prd), .pc_out(r16_pc)
    );

    csa_reduce_stage #(.xlen(xlen), .in_rows(rows_16)) reduce_16 (
        .clk(clk), .rst(rst), .valid_in(r16_valid), .rows_in(r16_rows), .neg_in(r16_neg),
        .high_in(r16_high), .prd_in(r16_prd), .pc_in(r16_pc),
        .valid(r8_valid), .rows_out(r8_rows), .neg(r8_neg), .high(r8_high),
        .prd_out(r8_prd), .pc_out(r8_pc)
    );

    csa_reduce_stage #(.xlen(xlen), .in_rows(rows_8)) reduce_8 (
        .clk(clk), .rst(rst), .valid_in(r8_valid), .rows_in(r8_rows), .neg_in(r8_neg),
        .high_in(r8_high), .prd_in(r8_prd), .pc_in(r8_pc),
        .valid(r4_valid), .rows_out(r4_rows), .neg(r4_neg), .high(r4_high),
        .prd_out(r4_prd), .pc_out(r4_pc)
    );

    csa_reduce_stage #(.xlen(xlen), .in_rows(rows_4)) reduce_4 (
        .clk(clk), .rst(rst), .valid_in(r4_valid), .rows_in(r4_rows), .neg_in(r4_neg),
        .high_in(r4_high), .prd_in(r4_prd), .pc_in(r4_pc),
        .valid(r2_valid), .rows_out(r2_rows), .neg(r2_neg), .high(r2_high),
        .prd_out(r2_prd), .pc_out(r2_pc)
    );

    product_resolve_stage #(.xlen(xlen)) resolve (
        .clk(clk), .rst(rst), .valid_in(r2_valid), .rows_in(r2_rows), .neg_in(r2_neg),
        .high_in(r2_high), .prd_in(r2_prd), .pc_in(r2_pc),
        .done(done), .result(result), .prd_out(prd_out), .pc_out(pc_out)
    );

endmodule

// ==== logic/partial_product_stage.sv ====
`timescale 1ns/1ns

module partial_product_stage import mul_pkg::*; #(
    parameter int xlen = 32,
    localparam int row_w = 2 * xlen
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_in,
    input  logic [xlen-1:0]         mag_a,
    input  logic [xlen-1:0]         mag_b,
    input  logic                    neg_in,
    input  logic                    high_in,
    input  logic [prd_width-1:0]    prd_in,
    input  logic [pc_width-1:0]     pc_in,
    output logic                    valid,
    output logic [xlen*row_w-1:0]   rows,
    output logic                    neg,
    output logic                    high,
    output logic [prd_width-1:0]    prd_out,
    output logic [pc_width-1:0]     pc_out
);

    logic [xlen*row_w-1:0] rows_next;

    // one row per multiplier bit, shifted into place
    always_comb begin
        for (int i = 0; i < xlen; i++) begin
            rows_next[i*row_w +: row_w] = mag_b[i] ? (row_w'(mag_a) << i) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_in;
        end
    end

    // data and tags follow valid
    always_ff @(posedge clk) begin
        rows    <= rows_next;
        neg     <= neg_in;
        high    <= high_in;
        prd_out <= prd_in;
        pc_out  <= pc_in;
    end

endmodule

// ==== logic/product_resolve_stage.sv ====
`timescale 1ns/1ns

module product_resolve_stage import mul_pkg::*; #(
    parameter int xlen = 32,
    localparam int row_w = 2 * xlen
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid_in,
    input  logic [2*row_w-1:0]   rows_in,
    input  logic                 neg_in,
    input  logic                 high_in,
    input  logic [prd_width-1:0] prd_in,
    input  logic [pc_width-1:0]  pc_in,
    output logic                 done,
    output logic [xlen-1:0]      result,
    output logic [prd_width-1:0] prd_out,
    output logic [pc_width-1:0]  pc_out
);

    logic [row_w-1:0] sum;
    logic [row_w-1:0] product;

    // carry-propagate add of the last sum and carry rows
    assign sum = rows_in[0 +: row_w] + rows_in[row_w +: row_w];

    // back to signed when exactly one signed operand was negative
    assign product = neg_in ? -sum : sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            done    <= 1'b0;
            result  <= '0;
            prd_out <= '0;
            pc_out  <= '0;
        end else if (valid_in) begin
            done    <= 1'b1;
            result  <= high_in ? product[row_w-1:xlen] : product[xlen-1:0];
            prd_out <= prd_in;
            pc_out  <= pc_in;
        end else begin
            // bubble, all zero
            done    <= 1'b0;
            result  <= '0;
            prd_out <= '0;
            pc_out  <= '0;
        end
    end

    result_known: assert property (
        @(posedge clk) disable iff (rst)
        done |-> !$isunknown(result)
    ) else $error("product_resolve_stage: result has unknown bits while done is high");

endmodule
